/* source/id_pkg.sv */
package id_pkg;

        localparam int xlen = 32;
        localparam int reg_addr_w = 5;
        localparam int alu_op_w = 12;

        localparam logic [reg_addr_w-1:0] link_reg = 5'd1;

        // register-register forms, matched on inst[31:15].
        localparam logic [16:0] op_add_w = 17'h00020;
        localparam logic [16:0] op_sub_w = 17'h00022;
        localparam logic [16:0] op_slt = 17'h00024;
        localparam logic [16:0] op_sltu = 17'h00025;
        localparam logic [16:0] op_nor = 17'h00028;
        localparam logic [16:0] op_and = 17'h00029;
        localparam logic [16:0] op_or = 17'h0002a;
        localparam logic [16:0] op_xor = 17'h0002b;
        localparam logic [16:0] op_sll_w = 17'h0002e;
        localparam logic [16:0] op_srl_w = 17'h0002f;
        localparam logic [16:0] op_sra_w = 17'h00030;
        localparam logic [16:0] op_slli_w = 17'h00081;
        localparam logic [16:0] op_srli_w = 17'h00089;
        localparam logic [16:0] op_srai_w = 17'h00091;

        // 12-bit immediate forms and memory access, matched on inst[31:22].
        localparam logic [9:0] op_slti = 10'h008;
        localparam logic [9:0] op_sltui = 10'h009;
        localparam logic [9:0] op_addi_w = 10'h00a;
        localparam logic [9:0] op_andi = 10'h00d;
        localparam logic [9:0] op_ori = 10'h00e;
        localparam logic [9:0] op_xori = 10'h00f;
        localparam logic [9:0] op_ld_b = 10'h0a0;
        localparam logic [9:0] op_ld_h = 10'h0a1;
        localparam logic [9:0] op_ld_w = 10'h0a2;
        localparam logic [9:0] op_st_b = 10'h0a4;
        localparam logic [9:0] op_st_h = 10'h0a5;
        localparam logic [9:0] op_st_w = 10'h0a6;
        localparam logic [9:0] op_ld_bu = 10'h0a8;
        localparam logic [9:0] op_ld_hu = 10'h0a9;

        // the 20-bit immediate forms use inst[31:25].
        localparam logic [6:0] op_lu12i_w = 7'h0a;
        localparam logic [6:0] op_pcaddu12i = 7'h0e;

        localparam logic [5:0] op_jirl = 6'h13;
        localparam logic [5:0] op_b = 6'h14;
        localparam logic [5:0] op_bl = 6'h15;
        localparam logic [5:0] op_beq = 6'h16;
        localparam logic [5:0] op_bne = 6'h17;
        localparam logic [5:0] op_blt = 6'h18;
        localparam logic [5:0] op_bge = 6'h19;
        localparam logic [5:0] op_bltu = 6'h1a;
        localparam logic [5:0] op_bgeu = 6'h1b;

        // bit 0 is add, up to bit 11 which is lui.
        typedef logic [alu_op_w-1:0] alu_op_t;

        typedef enum logic [1:0] {
                mem_byte = 2'd0,
                mem_half = 2'd1,
                mem_word = 2'd2
        } mem_size_t;

        typedef struct packed {
                logic            predict;
                logic [xlen-1:0] inst;
                logic [xlen-1:0] pc;
        } fetch_bundle_t;

        typedef struct packed {
                logic                  valid;
                logic [reg_addr_w-1:0] addr;
                logic [xlen-1:0]       data;
        } fwd_t;

        typedef struct packed {
                logic            done;
                logic [xlen-1:0] pc;
                logic [xlen-1:0] data;
        } load_return_t;

        typedef struct packed {
                logic beq;
                logic bne;
                logic blt;
                logic bge;
                logic bltu;
                logic bgeu;
                logic b;
                logic bl;
                logic jirl;
        } br_kind_t;

        typedef struct packed {
                alu_op_t               alu_op;
                logic                  src1_is_pc;
                logic                  src2_is_imm;
                logic [xlen-1:0]       imm;
                logic                  load;
                logic                  store;
                mem_size_t             mem_size;
                logic                  load_unsigned;
                logic                  gr_we;
                logic [reg_addr_w-1:0] dest;
                br_kind_t              br;
                logic [xlen-1:0]       br_offs;
        } dec_ctrl_t;

        typedef struct packed {
                logic                  valid;
                logic [xlen-1:0]       pc;
                logic [xlen-1:0]       src1;
                logic [xlen-1:0]       src2;
                alu_op_t               alu_op;
                logic                  load;
                logic                  store;
                mem_size_t             mem_size;
                logic                  load_unsigned;
                logic                  gr_we;
                logic [xlen-1:0]       store_data;
                logic [reg_addr_w-1:0] dest;
        } id_to_ex_t;

endpackage

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
        import id_pkg::*;
(
        input  logic [xlen-1:0]       inst,
        output dec_ctrl_t             ctrl,
        output logic [reg_addr_w-1:0] raddr1,
        output logic [reg_addr_w-1:0] raddr2
);

logic is_add, is_sub, is_slt, is_sltu, is_nor, is_and, is_or, is_xor;
logic is_sll, is_srl, is_sra, is_slli, is_srli, is_srai;
logic is_addi, is_slti, is_sltui, is_andi, is_ori, is_xori;
logic is_lu12i, is_pcaddu12i;
logic is_ld_b, is_ld_h, is_ld_w, is_ld_bu, is_ld_hu;
logic is_st_b, is_st_h, is_st_w;
logic need_ui12, need_si20, src2_is_4, cond_br, src_reg_is_rd;

assign is_add = (inst[31:15] == op_add_w);
assign is_sub = (inst[31:15] == op_sub_w);
assign is_slt = (inst[31:15] == op_slt);
assign is_sltu = (inst[31:15] == op_sltu);
assign is_nor = (inst[31:15] == op_nor);
assign is_and = (inst[31:15] == op_and);
assign is_or = (inst[31:15] == op_or);
assign is_xor = (inst[31:15] == op_xor);
assign is_sll = (inst[31:15] == op_sll_w);
assign is_srl = (inst[31:15] == op_srl_w);
assign is_sra = (inst[31:15] == op_sra_w);
assign is_slli = (inst[31:15] == op_slli_w);
assign is_srli = (inst[31:15] == op_srli_w);
assign is_srai = (inst[31:15] == op_srai_w);

assign is_addi = (inst[31:22] == op_addi_w);
assign is_slti = (inst[31:22] == op_slti);
assign is_sltui = (inst[31:22] == op_sltui);
assign is_andi = (inst[31:22] == op_andi);
assign is_ori = (inst[31:22] == op_ori);
assign is_xori = (inst[31:22] == op_xori);
assign is_ld_b = (inst[31:22] == op_ld_b);
assign is_ld_h = (inst[31:22] == op_ld_h);
assign is_ld_w = (inst[31:22] == op_ld_w);
assign is_ld_bu = (inst[31:22] == op_ld_bu);
assign is_ld_hu = (inst[31:22] == op_ld_hu);
assign is_st_b = (inst[31:22] == op_st_b);
assign is_st_h = (inst[31:22] == op_st_h);
assign is_st_w = (inst[31:22] == op_st_w);

assign is_lu12i = (inst[31:25] == op_lu12i_w);
assign is_pcaddu12i = (inst[31:25] == op_pcaddu12i);

assign ctrl.br.jirl = (inst[31:26] == op_jirl);
assign ctrl.br.b = (inst[31:26] == op_b);
assign ctrl.br.bl = (inst[31:26] == op_bl);
assign ctrl.br.beq = (inst[31:26] == op_beq);
assign ctrl.br.bne = (inst[31:26] == op_bne);
assign ctrl.br.blt = (inst[31:26] == op_blt);
assign ctrl.br.bge = (inst[31:26] == op_bge);
assign ctrl.br.bltu = (inst[31:26] == op_bltu);
assign ctrl.br.bgeu = (inst[31:26] == op_bgeu);

assign cond_br = ctrl.br.beq | ctrl.br.bne | ctrl.br.blt | ctrl.br.bge
               | ctrl.br.bltu | ctrl.br.bgeu;

assign ctrl.load = is_ld_b | is_ld_h | is_ld_w | is_ld_bu | is_ld_hu;
assign ctrl.store = is_st_b | is_st_h | is_st_w;
assign ctrl.load_unsigned = is_ld_bu | is_ld_hu;
assign ctrl.mem_size = (is_ld_b | is_ld_bu | is_st_b) ? mem_byte :
                       (is_ld_h | is_ld_hu | is_st_h) ? mem_half : mem_word;

// address calculation and the link value of jirl/bl all go through the adder.
assign ctrl.alu_op = {is_lu12i,
                      is_sra | is_srai,
                      is_srl | is_srli,
                      is_sll | is_slli,
                      is_xor | is_xori,
                      is_or | is_ori,
                      is_nor,
                      is_and | is_andi,
                      is_sltu | is_sltui,
                      is_slt | is_slti,
                      is_sub,
                      is_add | is_addi | ctrl.load | ctrl.store | ctrl.br.jirl
                      | ctrl.br.bl | is_pcaddu12i};

assign need_ui12 = is_andi | is_ori | is_xori;
assign need_si20 = is_lu12i | is_pcaddu12i;
assign src2_is_4 = ctrl.br.jirl | ctrl.br.bl;

// ui5 shift amounts sit in the low bits of the si12 field.
assign ctrl.imm = src2_is_4 ? 32'd4 :
                  need_si20 ? {inst[24:5], 12'b0} :
                  need_ui12 ? {20'b0, inst[21:10]} :
                  {{20{inst[21]}}, inst[21:10]};

assign ctrl.br_offs = (ctrl.br.b | ctrl.br.bl) ?
                      {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0} :
                      {{14{inst[25]}}, inst[25:10], 2'b0};

assign ctrl.src1_is_pc = ctrl.br.jirl | ctrl.br.bl | is_pcaddu12i;
assign ctrl.src2_is_imm = is_slli | is_srli | is_srai | is_addi | is_slti | is_sltui
                        | need_ui12 | need_si20 | ctrl.load | ctrl.store | src2_is_4;

assign ctrl.gr_we = ~ctrl.store & ~cond_br & ~ctrl.br.b;
assign ctrl.dest = ctrl.br.bl ? link_reg : inst[4:0];

assign src_reg_is_rd = ctrl.store | cond_br;
assign raddr1 = inst[9:5];
assign raddr2 = src_reg_is_rd ? inst[4:0] : inst[14:10];

endmodule

/* source/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass
        import id_pkg::*;
(
        input  logic [reg_addr_w-1:0] raddr1,
        input  logic [reg_addr_w-1:0] raddr2,
        input  logic [xlen-1:0]       rf_rdata1,
        input  logic [xlen-1:0]       rf_rdata2,
        input  fwd_t                  ex_fwd,
        input  fwd_t                  mem_fwd,
        input  logic                  load_fwd,
        input  logic [reg_addr_w-1:0] load_dest,
        input  logic [xlen-1:0]       load_data,
        output logic [xlen-1:0]       rj_value,
        output logic [xlen-1:0]       rkd_value
);

// the youngest producer wins; the returning load is younger than anything in EX.
function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] addr,
                                         input logic [xlen-1:0] rf_data);
        if (addr == '0) begin
                return '0;
        end
        if (load_fwd && load_dest == addr) begin
                return load_data;
        end
        if (ex_fwd.valid && ex_fwd.addr == addr) begin
                return ex_fwd.data;
        end
        if (mem_fwd.valid && mem_fwd.addr == addr) begin
                return mem_fwd.data;
        end
        return rf_data;
endfunction

always_comb begin
        rj_value = pick(raddr1, rf_rdata1);
        rkd_value = pick(raddr2, rf_rdata2);
end

endmodule

/* source/branch_resolver.sv */
`timescale 1ns/1ps

module branch_resolver
        import id_pkg::*;
(
        input  dec_ctrl_t       ctrl,
        input  logic [xlen-1:0] pc,
        input  logic            predict,
        input  logic            valid,
        input  logic [xlen-1:0] rj_value,
        input  logic [xlen-1:0] rkd_value,
        output logic            id_flush,
        output logic [xlen-1:0] id_flush_target
);

logic eq;
logic lt;
logic ltu;
logic taken;

assign eq = (rj_value == rkd_value);
assign lt = ($signed(rj_value) < $signed(rkd_value));
assign ltu = (rj_value < rkd_value);

assign taken = valid & ((ctrl.br.beq & eq)
                      | (ctrl.br.bne & ~eq)
                      | (ctrl.br.blt & lt)
                      | (ctrl.br.bge & ~lt)
                      | (ctrl.br.bltu & ltu)
                      | (ctrl.br.bgeu & ~ltu)
                      | ctrl.br.b
                      | ctrl.br.bl
                      | ctrl.br.jirl);

assign id_flush_target = ctrl.br.jirl ? rj_value + ctrl.br_offs : pc + ctrl.br_offs;

// fetch cannot predict a register target, so jirl always redirects.
assign id_flush = valid & ((taken ^ predict) | ctrl.br.jirl);

endmodule

/* source/id_stage_ctrl.sv */
`timescale 1ns/1ps

module id_stage_ctrl
        import id_pkg::*;
(
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  ex_allowin,
        input  logic                  flush,
        input  logic [xlen-1:0]       fetch_pc,
        input  dec_ctrl_t             ctrl,
        input  logic [reg_addr_w-1:0] raddr1,
        input  logic [reg_addr_w-1:0] raddr2,
        input  logic [xlen-1:0]       rj_value,
        input  logic [xlen-1:0]       rkd_value,
        input  load_return_t          mem_done,
        input  logic                  id_flush,
        output logic                  valid,
        output logic                  id_allowin,
        output logic                  load_fwd,
        output logic [reg_addr_w-1:0] load_dest,
        output id_to_ex_t             id_to_ex
);

logic valid_q;
logic live;
logic last_load;
logic [xlen-1:0] last_pc;
logic load_hazard;
logic load_done;
logic stall;
logic advance;
id_to_ex_t issue;

assign live = valid_q & ~flush;

// an instruction reading the destination of the load now in MEM waits for its data.
assign load_hazard = last_load & (load_dest != '0)
                   & ((load_dest == raddr1) | (load_dest == raddr2));
assign load_done = mem_done.done & (mem_done.pc == last_pc);
assign stall = live & load_hazard & ~load_done;
assign load_fwd = load_hazard & load_done;

// valid marks an entry whose operands are final, so branches resolve only then.
assign valid = live & ~stall;
assign id_allowin = ~live | (~stall & ex_allowin);
assign advance = ex_allowin & ~stall;

always_ff @(posedge clk) begin
        if (rst) begin
                valid_q <= 1'b0;
        end else if (id_allowin) begin
                valid_q <= ~id_flush & ~flush;
        end
end

always_ff @(posedge clk) begin
        if (rst) begin
                last_load <= 1'b0;
        end else if (advance) begin
                last_load <= valid & ctrl.load;
        end
end

always_ff @(posedge clk) begin
        if (advance) begin
                load_dest <= ctrl.dest;
                last_pc <= fetch_pc;
        end
end

always_comb begin
        issue.valid = valid;
        issue.pc = fetch_pc;
        issue.src1 = ctrl.src1_is_pc ? fetch_pc : rj_value;
        issue.src2 = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        issue.alu_op = ctrl.alu_op;
        issue.load = ctrl.load;
        issue.store = ctrl.store;
        issue.mem_size = ctrl.mem_size;
        issue.load_unsigned = ctrl.load_unsigned;
        issue.gr_we = ctrl.gr_we;
        issue.store_data = rkd_value;
        issue.dest = ctrl.dest;
end

// a stalled entry leaves a bubble behind it in EX.
always_ff @(posedge clk) begin
        if (rst) begin
                id_to_ex <= '0;
        end else if (advance) begin
                id_to_ex <= issue;
        end else if (ex_allowin) begin
                id_to_ex <= '0;
        end
end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
        import id_pkg::*;
(
        input  logic                  clk,
        input  logic                  rst,
        input  fetch_bundle_t         fetch_in,
        output logic                  id_allowin,
        input  logic                  ex_allowin,
        output id_to_ex_t             id_to_ex,
        input  logic                  flush,
        input  fwd_t                  ex_fwd,
        input  fwd_t                  mem_fwd,
        input  load_return_t          mem_done,
        output logic [reg_addr_w-1:0] rf_raddr1,
        output logic [reg_addr_w-1:0] rf_raddr2,
        input  logic [xlen-1:0]       rf_rdata1,
        input  logic [xlen-1:0]       rf_rdata2,
        output logic                  id_flush,
        output logic [xlen-1:0]       id_flush_target
);

dec_ctrl_t ctrl;
logic [xlen-1:0] rj_value;
logic [xlen-1:0] rkd_value;
logic valid;
logic load_fwd;
logic [reg_addr_w-1:0] load_dest;

inst_decoder u_inst_decoder (
        .inst   (fetch_in.inst),
        .ctrl   (ctrl),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2)
);

operand_bypass u_operand_bypass (
        .raddr1    (rf_raddr1),
        .raddr2    (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .load_fwd  (load_fwd),
        .load_dest (load_dest),
        .load_data (mem_done.data),
        .rj_value  (rj_value),
        .rkd_value (rkd_value)
);

branch_resolver u_branch_resolver (
        .ctrl            (ctrl),
        .pc              (fetch_in.pc),
        .predict         (fetch_in.predict),
        .valid           (valid),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .id_flush        (id_flush),
        .id_flush_target (id_flush_target)
);

id_stage_ctrl u_id_stage_ctrl (
        .clk        (clk),
        .rst        (rst),
        .ex_allowin (ex_allowin),
        .flush      (flush),
        .fetch_pc   (fetch_in.pc),
        .ctrl       (ctrl),
        .raddr1     (rf_raddr1),
        .raddr2     (rf_raddr2),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .mem_done   (mem_done),
        .id_flush   (id_flush),
        .valid      (valid),
        .id_allowin (id_allowin),
        .load_fwd   (load_fwd),
        .load_dest  (load_dest),
        .id_to_ex   (id_to_ex)
);

endmodule

/* verif/decode_stage_chk.sv */
`timescale 1ns/1ps

module decode_stage_chk
        import id_pkg::*;
(
        input logic      clk,
        input logic      rst,
        input logic      ex_allowin,
        input id_to_ex_t id_to_ex,
        input logic      id_flush
);

// the first reset edge only clears the registers, so checks start one edge later.
logic rst_seen = 1'b0;

always_ff @(posedge clk) begin
        rst_seen <= rst;
end

a_valid_in_reset: assert property (@(posedge clk) (rst && rst_seen) |-> !id_to_ex.valid)
        else $error("id_to_ex.valid high during reset");

a_flush_in_reset: assert property (@(posedge clk) (rst && rst_seen) |-> !id_flush)
        else $error("id_flush high during reset");

a_hold: assert property (@(posedge clk) disable iff (rst) !ex_allowin |=> $stable(id_to_ex))
        else $error("id_to_ex changed while ex_allowin was low");

endmodule

/* verif/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb
        import id_pkg::*;
;

localparam logic [11:0] a_add = 12'h001;
localparam logic [11:0] a_sub = 12'h002;
localparam logic [11:0] a_sltu = 12'h008;
localparam logic [11:0] a_or = 12'h040;
localparam logic [11:0] a_sra = 12'h400;
localparam logic [11:0] a_lui = 12'h800;
localparam logic [31:0] nop = {op_addi_w, 22'h0};

typedef struct packed {
        fetch_bundle_t fin;
        fwd_t          exf;
        fwd_t          memf;
        logic [3:0]    md_delay;
        logic [31:0]   md_pc;
        logic [31:0]   md_data;
        logic [3:0]    hold;
        id_to_ex_t     exp;
        logic          exp_flush;
        logic [31:0]   exp_target;
} row_t;

logic clk;
logic rst;
fetch_bundle_t fetch_in;
logic id_allowin;
logic ex_allowin;
id_to_ex_t id_to_ex;
logic flush;
fwd_t ex_fwd;
fwd_t mem_fwd;
load_return_t mem_done;
logic [4:0] rf_raddr1;
logic [4:0] rf_raddr2;
logic [31:0] rf_rdata1;
logic [31:0] rf_rdata2;
logic id_flush;
logic [31:0] id_flush_target;

row_t rows[$];
int errors = 0;
int checks = 0;
logic [31:0] cur_pc;
fwd_t cur_exf;
fwd_t cur_memf;
logic [3:0] cur_md_delay;
logic [31:0] cur_md_pc;
logic [31:0] cur_md_data;
logic [4:0] cur_ld_dest;
logic [3:0] cur_hold;

function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
endfunction

// each register holds a fixed value drawn from the generator.
function automatic logic [31:0] rf_val(input logic [4:0] r);
        logic [31:0] x;
        x = 32'd39869;
        for (int i = 0; i <= r; i++) begin
                x = lcg_next(x);
        end
        return (r == 0) ? 32'h0 : x;
endfunction

assign rf_rdata1 = rf_val(rf_raddr1);
assign rf_rdata2 = rf_val(rf_raddr2);

decode_stage u_decode_stage (
        .clk             (clk),
        .rst             (rst),
        .fetch_in        (fetch_in),
        .id_allowin      (id_allowin),
        .ex_allowin      (ex_allowin),
        .id_to_ex        (id_to_ex),
        .flush           (flush),
        .ex_fwd          (ex_fwd),
        .mem_fwd         (mem_fwd),
        .mem_done        (mem_done),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .id_flush        (id_flush),
        .id_flush_target (id_flush_target)
);

bind decode_stage decode_stage_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .ex_allowin (ex_allowin),
        .id_to_ex   (id_to_ex),
        .id_flush   (id_flush)
);

initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
end

function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
endfunction

function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_i12(input logic [9:0] op, input logic [4:0] rd,
                                        input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
endfunction

function automatic logic [31:0] enc_br(input logic [5:0] op, input logic [4:0] rj,
                                       input logic [4:0] rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
endfunction

// value an operand must have: zero register, then EX, then MEM, then the register file.
function automatic logic [31:0] opnd(input logic [4:0] r);
        if (r == 0) begin
                return 32'h0;
        end
        if (cur_exf.valid && cur_exf.addr == r) begin
                return cur_exf.data;
        end
        if (cur_memf.valid && cur_memf.addr == r) begin
                return cur_memf.data;
        end
        return rf_val(r);
endfunction

task automatic add_row(input logic [31:0] inst, input logic predict, input logic pc_src1,
                       input logic imm_src2, input logic [31:0] imm, input logic [11:0] alu,
                       input logic rd_src2, input logic gr_we, input logic [4:0] dest,
                       input logic ld, input logic st, input mem_size_t size,
                       input logic lu, input logic fl, input logic [31:0] tgt);
        row_t r;
        logic [4:0] r2;
        logic [31:0] v1;
        logic [31:0] v2;
        r2 = rd_src2 ? inst[4:0] : inst[14:10];
        v1 = opnd(inst[9:5]);
        v2 = opnd(r2);
        if (cur_md_delay != 0 && inst[9:5] == cur_ld_dest) begin
                v1 = cur_md_data;
        end
        if (cur_md_delay != 0 && r2 == cur_ld_dest) begin
                v2 = cur_md_data;
        end
        r.fin = {predict, inst, cur_pc};
        r.exf = cur_exf;
        r.memf = cur_memf;
        r.md_delay = cur_md_delay;
        r.md_pc = cur_md_pc;
        r.md_data = cur_md_data;
        r.hold = cur_hold;
        r.exp = {1'b1, cur_pc, pc_src1 ? cur_pc : v1, imm_src2 ? imm : v2, alu, ld, st,
                 size, lu, gr_we, v2, dest};
        r.exp_flush = fl;
        r.exp_target = tgt;
        rows.push_back(r);
        cur_pc = cur_pc + 4;
        cur_exf = '0;
        cur_memf = '0;
        cur_md_delay = 0;
        cur_hold = 0;
endtask

// kind: 0 beq, 1 bne, 2 blt, 3 bge, 4 bltu, 5 bgeu.
task automatic add_cond(input logic [5:0] op, input int kind, input logic [4:0] rj,
                        input logic [4:0] rd, input logic [15:0] offs, input logic predict);
        logic [31:0] v1;
        logic [31:0] v2;
        logic taken;
        v1 = opnd(rj);
        v2 = opnd(rd);
        case (kind)
                0: taken = (v1 == v2);
                1: taken = (v1 != v2);
                2: taken = ($signed(v1) < $signed(v2));
                3: taken = !($signed(v1) < $signed(v2));
                4: taken = (v1 < v2);
                default: taken = !(v1 < v2);
        endcase
        add_row(enc_br(op, rj, rd, offs), predict, 0, 0, 0, 12'h0, 1, 0, rd, 0, 0, mem_word,
                0, taken ^ predict, cur_pc + {{14{offs[15]}}, offs, 2'b0});
endtask

task automatic build_table();
        logic [31:0] inst;
        logic [25:0] o26;
        cur_pc = 32'h1c00_0000;
        cur_exf = '0;
        cur_memf = '0;
        cur_md_delay = 0;
        cur_hold = 0;
        add_row(enc_3r(op_add_w, 5, 6, 7), 0, 0, 0, 0, a_add, 0, 1, 5, 0, 0, mem_word, 0, 0, 0);
        add_row(enc_3r(op_sub_w, 8, 9, 10), 0, 0, 0, 0, a_sub, 0, 1, 8, 0, 0, mem_word, 0, 0, 0);
        // a write to register 0 offered by EX must not reach the operand.
        cur_exf = {1'b1, 5'd0, 32'heeee_0005};
        add_row(enc_3r(op_sltu, 11, 12, 0), 0, 0, 0, 0, a_sltu, 0, 1, 11, 0, 0, mem_word, 0, 0, 0);
        add_row(enc_i12(op_addi_w, 4, 3, 12'hffb), 0, 0, 1, sext12(12'hffb), a_add, 0, 1, 4,
                0, 0, mem_word, 0, 0, 0);
        add_row(enc_i12(op_ori, 4, 3, 12'h8f0), 0, 0, 1, 32'h8f0, a_or, 0, 1, 4,
                0, 0, mem_word, 0, 0, 0);
        // the si12 field of srai.w holds the low opcode bits above the shift amount.
        inst = enc_3r(op_srai_w, 2, 3, 7);
        add_row(inst, 0, 0, 1, {20'h0, op_srai_w[6:0], 5'd7}, a_sra, 0, 1, 2,
                0, 0, mem_word, 0, 0, 0);
        add_row({op_lu12i_w, 20'h12345, 5'd9}, 0, 0, 1, 32'h1234_5000, a_lui, 0, 1, 9,
                0, 0, mem_word, 0, 0, 0);
        add_row({op_pcaddu12i, 20'h00010, 5'd10}, 0, 1, 1, 32'h0001_0000, a_add, 0, 1, 10,
                0, 0, mem_word, 0, 0, 0);
        add_row(enc_i12(op_ld_w, 12, 13, 12'd16), 0, 0, 1, 32'd16, a_add, 0, 1, 12,
                1, 0, mem_word, 0, 0, 0);
        add_row(enc_i12(op_ld_bu, 14, 15, 12'hffc), 0, 0, 1, sext12(12'hffc), a_add, 0, 1, 14,
                1, 0, mem_byte, 1, 0, 0);
        add_row(enc_i12(op_ld_h, 16, 17, 12'd2), 0, 0, 1, 32'd2, a_add, 0, 1, 16,
                1, 0, mem_half, 0, 0, 0);
        add_row(enc_i12(op_st_b, 18, 19, 12'd8), 0, 0, 1, 32'd8, a_add, 1, 0, 18,
                0, 1, mem_byte, 0, 0, 0);
        add_row(enc_i12(op_st_h, 20, 21, 12'hffe), 0, 0, 1, sext12(12'hffe), a_add, 1, 0, 20,
                0, 1, mem_half, 0, 0, 0);
        add_row(enc_i12(op_st_w, 22, 23, 12'h020), 0, 0, 1, 32'h20, a_add, 1, 0, 22,
                0, 1, mem_word, 0, 0, 0);
        cur_exf = {1'b1, 5'd24, 32'haaaa_0001};
        cur_memf = {1'b1, 5'd24, 32'hbbbb_0002};
        add_row(enc_3r(op_add_w, 3, 24, 24), 0, 0, 0, 0, a_add, 0, 1, 3, 0, 0, mem_word, 0, 0, 0);
        cur_exf = {1'b1, 5'd9, 32'hcccc_0003};
        cur_memf = {1'b1, 5'd25, 32'hdddd_0004};
        add_row(enc_3r(op_add_w, 3, 25, 26), 0, 0, 0, 0, a_add, 0, 1, 3, 0, 0, mem_word, 0, 0, 0);
        add_cond(op_beq, 0, 6, 6, 16'h0010, 0);
        add_cond(op_bne, 1, 6, 6, 16'h0010, 0);
        add_cond(op_blt, 2, 6, 7, 16'hfff0, 1);
        add_cond(op_bge, 3, 6, 7, 16'h0040, 0);
        add_cond(op_bltu, 4, 7, 6, 16'h0008, 1);
        add_cond(op_bgeu, 5, 7, 6, 16'hff00, 1);
        o26 = 26'h3ff_fff0;
        inst = {op_b, o26[15:0], o26[25:16]};
        add_row(inst, 1, 0, 0, 0, 12'h0, 0, 0, inst[4:0], 0, 0, mem_word, 0, 0,
                cur_pc + {{4{o26[25]}}, o26, 2'b0});
        o26 = 26'h000_0123;
        add_row({op_bl, o26[15:0], o26[25:16]}, 0, 1, 1, 32'd4, a_add, 0, 1, link_reg,
                0, 0, mem_word, 0, 1, cur_pc + {4'h0, o26, 2'b0});
        add_row(enc_br(op_jirl, 6, 1, 16'h0021), 1, 1, 1, 32'd4, a_add, 0, 1, 1,
                0, 0, mem_word, 0, 1, opnd(6) + 32'h84);
        cur_md_pc = cur_pc;
        add_row(enc_i12(op_ld_w, 27, 28, 12'd0), 0, 0, 1, 32'd0, a_add, 0, 1, 27,
                1, 0, mem_word, 0, 0, 0);
        cur_md_delay = 3;
        cur_md_data = 32'hdead_beef;
        cur_ld_dest = 27;
        add_row(enc_3r(op_add_w, 29, 27, 6), 0, 0, 0, 0, a_add, 0, 1, 29, 0, 0, mem_word, 0, 0, 0);
        cur_hold = 3;
        add_row(enc_3r(op_or, 5, 6, 7), 0, 0, 0, 0, a_or, 0, 1, 5, 0, 0, mem_word, 0, 0, 0);
        add_row(enc_3r(op_add_w, 8, 5, 7), 0, 0, 0, 0, a_add, 0, 1, 8, 0, 0, mem_word, 0, 0, 0);
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
endtask

task automatic fail_timeout(input string what);
        errors++;
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
endtask

// an empty stage accepts on the next edge; the instruction itself comes with each row.
task automatic refill();
        fetch_in = {1'b0, nop, 32'h0};
        mem_done.done = 1'b0;
        @(negedge clk);
endtask

task automatic apply_row(input row_t r);
        int c;
        logic ea;
        id_to_ex_t snap;
        fetch_in = r.fin;
        ex_fwd = r.exf;
        mem_fwd = r.memf;
        // a completion that carries another pc does not end a load-use stall.
        mem_done = {r.md_delay != 0, r.md_pc - 32'd4, r.md_data};
        ex_allowin = (r.hold == 0);
        snap = id_to_ex;
        c = 0;
        #1;
        while (!id_allowin) begin
                ea = ex_allowin;
                @(negedge clk);
                if (ea) begin
                        check_val("bubble id_to_ex", id_to_ex[31:0], 32'h0);
                        check_val("bubble valid", id_to_ex.valid, 1'b0);
                end else begin
                        check_val("held id_to_ex.pc", id_to_ex.pc, snap.pc);
                        check_val("held id_to_ex.src1", id_to_ex.src1, snap.src1);
                end
                c++;
                if (r.hold != 0 && c == r.hold) begin
                        ex_allowin = 1'b1;
                end
                if (r.md_delay != 0 && c == r.md_delay) begin
                        mem_done.pc = r.md_pc;
                end
                if (c > 32) begin
                        fail_timeout("id_allowin");
                end
                #1;
        end
        if (r.hold != 0 && c != r.hold) begin
                errors++;
                $display("id_allowin rose after %0d of %0d held cycles", c, r.hold);
        end
        if (r.md_delay != 0 && c != r.md_delay) begin
                errors++;
                $display("load-use stall lasted %0d cycles instead of %0d", c, r.md_delay);
        end
        check_val("id_flush", id_flush, r.exp_flush);
        if (r.exp_flush) begin
                check_val("id_flush_target", id_flush_target, r.exp_target);
        end
        @(negedge clk);
        check_val("valid", id_to_ex.valid, r.exp.valid);
        check_val("pc", id_to_ex.pc, r.exp.pc);
        check_val("src1", id_to_ex.src1, r.exp.src1);
        check_val("src2", id_to_ex.src2, r.exp.src2);
        check_val("alu_op", id_to_ex.alu_op, r.exp.alu_op);
        check_val("load", id_to_ex.load, r.exp.load);
        check_val("store", id_to_ex.store, r.exp.store);
        check_val("mem_size", id_to_ex.mem_size, r.exp.mem_size);
        check_val("load_unsigned", id_to_ex.load_unsigned, r.exp.load_unsigned);
        check_val("gr_we", id_to_ex.gr_we, r.exp.gr_we);
        check_val("store_data", id_to_ex.store_data, r.exp.store_data);
        check_val("dest", id_to_ex.dest, r.exp.dest);
        if (r.exp_flush) begin
                refill();
        end
endtask

initial begin
        rst = 1'b1;
        fetch_in = {1'b0, nop, 32'h0};
        ex_allowin = 1'b1;
        flush = 1'b0;
        ex_fwd = '0;
        mem_fwd = '0;
        mem_done = '0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        refill();
        foreach (rows[i]) begin
                apply_row(rows[i]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
                $display("ALL CHECKS PASSED");
        end else begin
                $display("CHECKS FAILED");
        end
        $finish;
end

endmodule

/* list.f */
source/id_pkg.sv
source/inst_decoder.sv
source/operand_bypass.sv
source/branch_resolver.sv
source/id_stage_ctrl.sv
source/decode_stage.sv
verif/decode_stage_chk.sv
verif/decode_stage_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - source/id_pkg.sv
  - source/inst_decoder.sv
  - source/operand_bypass.sv
  - source/branch_resolver.sv
  - source/id_stage_ctrl.sv
  - source/decode_stage.sv
  - target: test
    files:
      - verif/decode_stage_chk.sv
      - verif/decode_stage_tb.sv
